/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := dbg_tb
FILELIST := sim.f
OBJ_DIR  := obj_dir
LOG      := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "sim passed" $(LOG)

lint:
	$(SIM) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* dv/dbg_tb.sv */
//----------------------------------------
// Testbench for the debug module, runs a
// DMI table against a two-hart model
//----------------------------------------

`include "dbg_macros.svh"

module dbg_tb;

	localparam int N = `DBG_N_HARTS;
	localparam int XLEN = `DBG_XLEN;
	localparam int HALT_DELAY = 3;
	localparam int RESUME_DELAY = 2;
	localparam int WAIT_LIMIT = 50;

	localparam bit RD = 1'b0;
	localparam bit WR = 1'b1;
	localparam bit OK = 1'b0;
	localparam bit ERR = 1'b1;

	localparam logic [`DBG_DMI_AW-1:0] A_DATA0 = 9'h04;
	localparam logic [`DBG_DMI_AW-1:0] A_UNMAPPED = 9'h05;
	localparam logic [`DBG_DMI_AW-1:0] A_DMCONTROL = 9'h10;
	localparam logic [`DBG_DMI_AW-1:0] A_DMSTATUS = 9'h11;
	localparam logic [`DBG_DMI_AW-1:0] A_HALTSUM0 = 9'h40;

	// dmcontrol fields
	localparam logic [XLEN-1:0] HALTREQ = 32'h8000_0000;
	localparam logic [XLEN-1:0] RESUMEREQ = 32'h4000_0000;
	localparam logic [XLEN-1:0] HARTRESET = 32'h2000_0000;
	localparam logic [XLEN-1:0] ACKHAVERESET = 32'h1000_0000;
	localparam logic [XLEN-1:0] SEL1 = 32'h0001_0000;
	localparam logic [XLEN-1:0] NDMRESET = 32'h0000_0002;
	localparam logic [XLEN-1:0] ACTIVE = 32'h0000_0001;

	typedef enum {WAIT_NONE, WAIT_STATUS, WAIT_RELEASE} wait_e;

	typedef struct {
		string                  name;
		bit                     wr;
		logic [`DBG_DMI_AW-1:0] addr;
		logic [XLEN-1:0]        wdata;
		logic [XLEN-1:0]        exp_rdata;
		bit                     exp_err;
		logic [N-1:0]           exp_halt;
		logic [N-1:0]           exp_resume;
		logic [N:0]             exp_rst;
		wait_e                  wait_kind;
		int                     wait_bit;
	} dmi_op_t;

	logic                   clk;
	logic                   rst_n;
	logic                   dmi_psel;
	logic                   dmi_penable;
	logic                   dmi_pwrite;
	logic [`DBG_DMI_AW-1:0] dmi_paddr;
	logic [XLEN-1:0]        dmi_pwdata;
	logic [XLEN-1:0]        dmi_prdata;
	logic                   dmi_pslverr;
	logic [N-1:0]           hart_req_halt;
	logic [N-1:0]           hart_req_resume;
	logic [N-1:0]           hart_halted;
	logic [N-1:0]           hart_running;
	logic [N-1:0]           data0_wen;
	logic [N*XLEN-1:0]      data0_wdata;
	logic [XLEN-1:0]        data0;
	logic [N-1:0]           hart_rst_n;
	logic                   sys_rst_n;

	dmi_op_t     ops[$];
	logic [15:0] lfsr_q = 16'd49936;
	int          checks = 0;
	int          errors = 0;
	int          halt_wait[N];
	int          resume_wait[N];

	dbg_top DUT (
		.i_clk              (clk),
		.i_rst_n            (rst_n),
		.i_dmi_psel         (dmi_psel),
		.i_dmi_penable      (dmi_penable),
		.i_dmi_pwrite       (dmi_pwrite),
		.i_dmi_paddr        (dmi_paddr),
		.i_dmi_pwdata       (dmi_pwdata),
		.o_dmi_prdata       (dmi_prdata),
		.o_dmi_pslverr      (dmi_pslverr),
		.o_hart_req_halt    (hart_req_halt),
		.o_hart_req_resume  (hart_req_resume),
		.i_hart_halted      (hart_halted),
		.i_hart_running     (hart_running),
		.i_hart_data0_wen   (data0_wen),
		.i_hart_data0_wdata (data0_wdata),
		.o_data0            (data0),
		.o_hart_rst_n       (hart_rst_n),
		.o_sys_rst_n        (sys_rst_n)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Hart model: halts a few cycles after a halt request, resumes after a resume request
	initial begin
		hart_halted = '0;
		hart_running = '0;
		forever begin
			@(posedge clk);
			#5;
			for (int h = 0; h < N; h++) begin
				if (!hart_rst_n[h]) begin
					hart_halted[h] = 1'b0;
					hart_running[h] = 1'b0;
					halt_wait[h] = 0;
					resume_wait[h] = 0;
				end else if (!hart_halted[h]) begin
					hart_running[h] = 1'b1;
					halt_wait[h] = hart_req_halt[h] ? halt_wait[h] + 1 : 0;
					if (halt_wait[h] == HALT_DELAY) begin
						hart_halted[h] = 1'b1;
						hart_running[h] = 1'b0;
						halt_wait[h] = 0;
					end
				end else begin
					resume_wait[h] = hart_req_resume[h] ? resume_wait[h] + 1 : 0;
					if (resume_wait[h] == RESUME_DELAY) begin
						hart_halted[h] = 1'b0;
						hart_running[h] = 1'b1;
						resume_wait[h] = 0;
					end
				end
			end
		end
	end

	// 16-bit Fibonacci LFSR, taps 16 14 13 11
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
		lfsr_q = {lfsr_q[14:0], fb};
		return fb;
	endfunction

	function automatic logic [XLEN-1:0] lfsr_word();
		logic [XLEN-1:0] w;
		w = '0;
		for (int i = 0; i < XLEN; i++)
			w = {w[XLEN-2:0], lfsr_bit()};
		return w;
	endfunction

	// Selected hart view, flags are {halted, running, resumeack, havereset}
	function automatic logic [XLEN-1:0] status_word(input logic [3:0] flags);
		logic [XLEN-1:0] w;
		w = '0;
		w[9:8] = {2{flags[3]}};
		w[11:10] = {2{flags[2]}};
		w[17:16] = {2{flags[1]}};
		w[19:18] = {2{flags[0]}};
		// authenticated, version 2
		w[7] = 1'b1;
		w[3:0] = 4'd2;
		return w;
	endfunction

	function automatic void add_op(input string name, input bit wr,
		input logic [`DBG_DMI_AW-1:0] addr, input logic [XLEN-1:0] wdata,
		input logic [XLEN-1:0] exp_rdata, input bit exp_err,
		input logic [N-1:0] exp_halt = '0, input logic [N-1:0] exp_resume = '0,
		input logic [N:0] exp_rst = '1, input wait_e wait_kind = WAIT_NONE,
		input int wait_bit = 0);
		dmi_op_t op;
		op.name = name;
		op.wr = wr;
		op.addr = addr;
		op.wdata = wdata;
		op.exp_rdata = exp_rdata;
		op.exp_err = exp_err;
		op.exp_halt = exp_halt;
		op.exp_resume = exp_resume;
		op.exp_rst = exp_rst;
		op.wait_kind = wait_kind;
		op.wait_bit = wait_bit;
		ops.push_back(op);
	endfunction

	task automatic next_cycle();
		@(posedge clk);
		#5;
	endtask

	task automatic check_rdata(input string name, input logic [XLEN-1:0] exp,
		input logic [XLEN-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: rdata expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_slverr(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: pslverr expected %b, actual %b", name, exp, act);
		end
	endtask

	// Reset vector is {sys, harts}
	task automatic check_rst(input string name, input logic [N:0] exp, input logic [N:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: resets expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_req(input string name, input logic [N-1:0] exp,
		input logic [N-1:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[ERROR] %s: requests expected %b, actual %b", name, exp, act);
		end
	endtask

	task automatic check_cycles(input string name, input int exp, input int act);
		checks++;
		if (act != exp) begin
			errors++;
			$display("[ERROR] %s: hold cycles expected %0d, actual %0d", name, exp, act);
		end
	endtask

	// Setup cycle, access cycle, sampled mid access
	task automatic dmi_xfer(input bit wr, input logic [`DBG_DMI_AW-1:0] addr,
		input logic [XLEN-1:0] wdata, output logic [XLEN-1:0] rdata, output logic slverr);
		dmi_psel = 1'b1;
		dmi_penable = 1'b0;
		dmi_pwrite = wr;
		dmi_paddr = addr;
		dmi_pwdata = wdata;
		next_cycle();
		dmi_penable = 1'b1;
		@(negedge clk);
		rdata = dmi_prdata;
		slverr = dmi_pslverr;
		next_cycle();
		dmi_psel = 1'b0;
		dmi_penable = 1'b0;
		dmi_pwrite = 1'b0;
	endtask

	task automatic wait_status_bit(input string name, input int bit_idx);
		logic [XLEN-1:0] rdata;
		logic            slverr;
		int              n;
		n = 0;
		rdata = '0;
		while (!rdata[bit_idx] && n < WAIT_LIMIT) begin
			dmi_xfer(RD, A_DMSTATUS, '0, rdata, slverr);
			n++;
		end
		if (!rdata[bit_idx]) begin
			errors++;
			$display("%s: dmstatus bit %0d never set within %0d reads", name, bit_idx, n);
		end
	endtask

	task automatic wait_release(input string name);
		int n;
		n = 0;
		while (!(sys_rst_n && &hart_rst_n) && n < WAIT_LIMIT) begin
			next_cycle();
			n++;
		end
		if (!(sys_rst_n && &hart_rst_n)) begin
			errors++;
			$display("%s: resets still held after %0d cycles", name, n);
		end else begin
			check_cycles(name, `DBG_RST_HOLD, n);
		end
	endtask

	task automatic build_table();
		logic [XLEN-1:0] value;
		add_op("dmstatus after reset", RD, A_DMSTATUS, '0, status_word(4'b0101), OK);
		add_op("unmapped address", RD, A_UNMAPPED, '0, '0, ERR);
		add_op("haltsum0 after reset", RD, A_HALTSUM0, '0, '0, OK);
		for (int i = 0; i < 2; i++) begin
			value = lfsr_word();
			add_op("data0 write", WR, A_DATA0, value, '0, OK);
			add_op("data0 read", RD, A_DATA0, '0, value, OK);
		end
		// DM still inactive
		add_op("haltreq while inactive", WR, A_DMCONTROL, HALTREQ | SEL1, '0, OK);
		add_op("dmcontrol while inactive", RD, A_DMCONTROL, '0, '0, OK);
		add_op("haltsum0 while inactive", RD, A_HALTSUM0, '0, '0, OK);
		add_op("activate", WR, A_DMCONTROL, ACTIVE, '0, OK);
		add_op("ack havereset hart 1", WR, A_DMCONTROL, ACKHAVERESET | SEL1 | ACTIVE, '0, OK);
		add_op("dmcontrol hartsel 1", RD, A_DMCONTROL, '0, SEL1 | ACTIVE, OK);
		add_op("dmstatus hart 1 running", RD, A_DMSTATUS, '0, status_word(4'b0100), OK);
		add_op("halt hart 1", WR, A_DMCONTROL, HALTREQ | SEL1 | ACTIVE, '0, OK,
			2'b10, 2'b00, 3'b111, WAIT_STATUS, 9);
		add_op("dmstatus hart 1 halted", RD, A_DMSTATUS, '0, status_word(4'b1000), OK);
		add_op("haltsum0 hart 1 halted", RD, A_HALTSUM0, '0, 32'h2, OK);
		// Resume is dropped when haltreq is written with it
		add_op("resumereq with haltreq", WR, A_DMCONTROL,
			HALTREQ | RESUMEREQ | SEL1 | ACTIVE, '0, OK);
		add_op("dmstatus still halted", RD, A_DMSTATUS, '0, status_word(4'b1000), OK);
		add_op("resume hart 1", WR, A_DMCONTROL, RESUMEREQ | SEL1 | ACTIVE, '0, OK,
			2'b00, 2'b10, 3'b111, WAIT_STATUS, 17);
		add_op("dmstatus hart 1 resumed", RD, A_DMSTATUS, '0, status_word(4'b0110), OK);
		add_op("haltsum0 after resume", RD, A_HALTSUM0, '0, '0, OK);
		add_op("ack havereset hart 0", WR, A_DMCONTROL, ACKHAVERESET | ACTIVE, '0, OK);
		add_op("dmstatus hart 0 acked", RD, A_DMSTATUS, '0, status_word(4'b0100), OK);
		add_op("hartreset hart 0", WR, A_DMCONTROL, HARTRESET | ACTIVE, '0, OK,
			2'b00, 2'b00, 3'b110);
		add_op("dmstatus in hartreset", RD, A_DMSTATUS, '0, status_word(4'b0000), OK,
			2'b00, 2'b00, 3'b110);
		add_op("hartreset cleared", WR, A_DMCONTROL, ACTIVE, '0, OK,
			2'b00, 2'b00, 3'b110, WAIT_RELEASE);
		add_op("havereset after hartreset", RD, A_DMSTATUS, '0, status_word(4'b0101), OK);
		add_op("ack after hartreset", WR, A_DMCONTROL, ACKHAVERESET | ACTIVE, '0, OK);
		add_op("havereset acked", RD, A_DMSTATUS, '0, status_word(4'b0100), OK);
		add_op("ndmreset", WR, A_DMCONTROL, NDMRESET | ACTIVE, '0, OK, 2'b00, 2'b00, 3'b000);
		add_op("ndmreset cleared", WR, A_DMCONTROL, ACTIVE, '0, OK,
			2'b00, 2'b00, 3'b000, WAIT_RELEASE);
		add_op("havereset after ndmreset", RD, A_DMSTATUS, '0, status_word(4'b0101), OK);
		add_op("select hart 1", WR, A_DMCONTROL, SEL1 | ACTIVE, '0, OK);
		add_op("hart 1 after ndmreset", RD, A_DMSTATUS, '0, status_word(4'b0111), OK);
		add_op("ack hart 1", WR, A_DMCONTROL, ACKHAVERESET | SEL1 | ACTIVE, '0, OK);
		add_op("hart 1 havereset acked", RD, A_DMSTATUS, '0, status_word(4'b0110), OK);
	endtask

	initial begin
		logic [XLEN-1:0] rdata;
		logic            slverr;
		logic [XLEN-1:0] value;

		rst_n = 1'b0;
		dmi_psel = 1'b0;
		dmi_penable = 1'b0;
		dmi_pwrite = 1'b0;
		dmi_paddr = '0;
		dmi_pwdata = '0;
		data0_wen = '0;
		data0_wdata = '0;
		repeat (10) @(posedge clk);
		#5;
		rst_n = 1'b1;
		wait_release("global reset release");

		build_table();
		foreach (ops[i]) begin
			dmi_xfer(ops[i].wr, ops[i].addr, ops[i].wdata, rdata, slverr);
			check_slverr(ops[i].name, ops[i].exp_err, slverr);
			if (!ops[i].wr && !ops[i].exp_err)
				check_rdata(ops[i].name, ops[i].exp_rdata, rdata);
			check_req({ops[i].name, " halt"}, ops[i].exp_halt, hart_req_halt);
			check_req({ops[i].name, " resume"}, ops[i].exp_resume, hart_req_resume);
			check_rst(ops[i].name, ops[i].exp_rst, {sys_rst_n, hart_rst_n});
			case (ops[i].wait_kind)
				WAIT_STATUS:  wait_status_bit(ops[i].name, ops[i].wait_bit);
				WAIT_RELEASE: wait_release(ops[i].name);
				default:      ;
			endcase
		end

		// Data0 seen on the hart side, then written by hart 1
		value = lfsr_word();
		dmi_xfer(WR, A_DATA0, value, rdata, slverr);
		check_rdata("o_data0 after DMI write", value, data0);
		value = lfsr_word();
		data0_wen[1] = 1'b1;
		data0_wdata[XLEN +: XLEN] = value;
		next_cycle();
		data0_wen = '0;
		check_rdata("o_data0 after hart write", value, data0);
		dmi_xfer(RD, A_DATA0, '0, rdata, slverr);
		check_rdata("data0 read after hart write", value, rdata);

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

/* hw/dbg_dmi_regs.sv */
//----------------------------------------
// DMI slave for data0, dmcontrol, dmstatus
// and haltsum0, no wait states
//----------------------------------------

`include "dbg_macros.svh"

module dbg_dmi_regs (
	input  logic                              i_clk,
	input  logic                              i_rst_n,

	input  logic                              i_dmi_psel,
	input  logic                              i_dmi_penable,
	input  logic                              i_dmi_pwrite,
	input  logic [`DBG_DMI_AW-1:0]            i_dmi_paddr,
	input  logic [`DBG_XLEN-1:0]              i_dmi_pwdata,
	output logic [`DBG_XLEN-1:0]              o_dmi_prdata,
	output logic                              o_dmi_pslverr,

	input  logic [`DBG_N_HARTS-1:0]           i_hart_data0_wen,
	input  logic [`DBG_N_HARTS*`DBG_XLEN-1:0] i_hart_data0_wdata,
	output logic [`DBG_XLEN-1:0]              o_data0,

	output logic [`DBG_N_HARTS-1:0]           o_hartreset,
	output logic                              o_ndmreset,

	dbg_hart_if.regs                          hart
);

	localparam int N = `DBG_N_HARTS;
	localparam int XLEN = `DBG_XLEN;

	dbg_regs_pkg::dmi_addr_e  addr;
	dbg_regs_pkg::dmcontrol_t wr_ctrl;
	dbg_regs_pkg::dmcontrol_t rd_ctrl;

	logic            access;
	logic            mapped;
	logic            wr_data0;
	logic            wr_dmcontrol;
	logic            wr_accept;
	logic [N-1:0]    wr_mask;
	logic [N-1:0]    sel_mask;

	logic            haltreq_q;
	logic            hartreset_q;
	logic            hartsel_q;
	logic            ndmreset_q;
	logic            dmactive_q;
	logic [N-1:0]    set_resume_q;
	logic [N-1:0]    ack_havereset_q;

	logic [XLEN-1:0] data0_q;
	logic [XLEN-1:0] dmstatus;
	logic [XLEN-1:0] haltsum0;

	// Access phase decode
	assign access = i_dmi_psel && i_dmi_penable;
	assign addr = dbg_regs_pkg::dmi_addr_e'(i_dmi_paddr);
	assign wr_ctrl = dbg_regs_pkg::dmcontrol_t'(i_dmi_pwdata);
	assign wr_data0 = access && i_dmi_pwrite && addr == dbg_regs_pkg::ADDR_DATA0;
	assign wr_dmcontrol = access && i_dmi_pwrite && addr == dbg_regs_pkg::ADDR_DMCONTROL;

	// Fields other than dmactive only land on an active DM that stays active
	assign wr_accept = wr_dmcontrol && dmactive_q && wr_ctrl.dmactive;

	assign wr_mask = N'(1) << wr_ctrl.hartsel;
	assign sel_mask = N'(1) << hartsel_q;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			haltreq_q <= 1'b0;
			hartreset_q <= 1'b0;
			hartsel_q <= 1'b0;
			ndmreset_q <= 1'b0;
			dmactive_q <= 1'b0;
		end else if (wr_dmcontrol) begin
			dmactive_q <= wr_ctrl.dmactive;
			if (wr_accept) begin
				haltreq_q <= wr_ctrl.haltreq;
				hartreset_q <= wr_ctrl.hartreset;
				hartsel_q <= wr_ctrl.hartsel;
				ndmreset_q <= wr_ctrl.ndmreset;
			end else begin
				haltreq_q <= 1'b0;
				hartreset_q <= 1'b0;
				hartsel_q <= 1'b0;
				ndmreset_q <= 1'b0;
			end
		end
	end

	// resumereq and ackhavereset are not stored, they fire once for the written hartsel
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			set_resume_q <= '0;
			ack_havereset_q <= '0;
		end else begin
			set_resume_q <= (wr_accept && wr_ctrl.resumereq && !wr_ctrl.haltreq) ? wr_mask : '0;
			ack_havereset_q <= (wr_accept && wr_ctrl.ackhavereset) ? wr_mask : '0;
		end
	end

	assign hart.set_halt = haltreq_q ? sel_mask : '0;
	assign hart.set_resume = set_resume_q;
	assign hart.ack_havereset = ack_havereset_q;
	assign o_hartreset = hartreset_q ? sel_mask : '0;
	assign o_ndmreset = ndmreset_q;

	// DMI write wins over any hart write in the same cycle
	always_ff @(posedge i_clk) begin
		if (wr_data0) begin
			data0_q <= i_dmi_pwdata;
		end else begin
			for (int i = 0; i < N; i++) begin
				if (i_hart_data0_wen[i])
					data0_q <= i_hart_data0_wdata[i*XLEN +: XLEN];
			end
		end
	end

	assign o_data0 = data0_q;

	always_comb begin
		rd_ctrl = '0;
		rd_ctrl.haltreq = haltreq_q;
		rd_ctrl.hartreset = hartreset_q;
		rd_ctrl.hartsel = hartsel_q;
		rd_ctrl.ndmreset = ndmreset_q;
		rd_ctrl.dmactive = dmactive_q;
	end

	// Only one hart is ever selected, so the all and any flags agree
	always_comb begin
		dmstatus = '0;
		dmstatus[19] = hart.havereset[hartsel_q];
		dmstatus[18] = hart.havereset[hartsel_q];
		dmstatus[17] = hart.resumeack[hartsel_q];
		dmstatus[16] = hart.resumeack[hartsel_q];
		dmstatus[11] = hart.running[hartsel_q];
		dmstatus[10] = hart.running[hartsel_q];
		dmstatus[9] = hart.halted[hartsel_q];
		dmstatus[8] = hart.halted[hartsel_q];
		dmstatus[7] = 1'b1;
		dmstatus[3:0] = dbg_regs_pkg::DMSTATUS_VERSION;
	end

	assign haltsum0 = XLEN'(hart.halted);

	always_comb begin
		mapped = 1'b1;
		o_dmi_prdata = '0;
		case (addr)
			dbg_regs_pkg::ADDR_DATA0:     o_dmi_prdata = data0_q;
			dbg_regs_pkg::ADDR_DMCONTROL: o_dmi_prdata = rd_ctrl;
			dbg_regs_pkg::ADDR_DMSTATUS:  o_dmi_prdata = dmstatus;
			dbg_regs_pkg::ADDR_HALTSUM0:  o_dmi_prdata = haltsum0;
			default:                      mapped = 1'b0;
		endcase
	end

	assign o_dmi_pslverr = access && !mapped;

	a_mapped_no_err: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(access && i_dmi_paddr inside {dbg_regs_pkg::ADDR_DATA0, dbg_regs_pkg::ADDR_DMCONTROL,
		dbg_regs_pkg::ADDR_DMSTATUS, dbg_regs_pkg::ADDR_HALTSUM0}) |-> !o_dmi_pslverr);

endmodule

/* hw/dbg_hart_ctrl.sv */
//----------------------------------------
// Halt/resume handshake per hart, with the
// sticky resumeack and havereset flags
//----------------------------------------

`include "dbg_macros.svh"

module dbg_hart_ctrl (
	input  logic                    i_clk,
	input  logic                    i_rst_n,

	input  logic [`DBG_N_HARTS-1:0] i_hart_rst_n,
	input  logic [`DBG_N_HARTS-1:0] i_rst_release,

	input  logic [`DBG_N_HARTS-1:0] i_hart_halted,
	input  logic [`DBG_N_HARTS-1:0] i_hart_running,
	output logic [`DBG_N_HARTS-1:0] o_hart_req_halt,
	output logic [`DBG_N_HARTS-1:0] o_hart_req_resume,

	dbg_hart_if.ctrl                hart
);

	localparam int N = `DBG_N_HARTS;

	for (genvar i = 0; i < N; i++) begin : g_hart
		dbg_hart_pkg::hart_state_e state_q;
		dbg_hart_pkg::hart_state_e state_d;
		logic                      resumeack_q;
		logic                      havereset_q;

		always_comb begin
			state_d = state_q;
			case (state_q)
				dbg_hart_pkg::HART_RESET: begin
					if (i_rst_release[i])
						state_d = dbg_hart_pkg::HART_RUNNING;
				end
				dbg_hart_pkg::HART_RUNNING: begin
					if (hart.set_halt[i])
						state_d = dbg_hart_pkg::HART_HALT_REQ;
				end
				dbg_hart_pkg::HART_HALT_REQ: begin
					if (i_hart_halted[i])
						state_d = dbg_hart_pkg::HART_HALTED;
				end
				dbg_hart_pkg::HART_HALTED: begin
					if (hart.set_resume[i])
						state_d = dbg_hart_pkg::HART_RESUME_REQ;
				end
				dbg_hart_pkg::HART_RESUME_REQ: begin
					// Hart has left debug mode and is executing again
					if (i_hart_running[i] && !i_hart_halted[i])
						state_d = dbg_hart_pkg::HART_RUNNING;
				end
				default: state_d = dbg_hart_pkg::HART_RESET;
			endcase
			// A hart held in reset restarts the handshake
			if (!i_hart_rst_n[i])
				state_d = dbg_hart_pkg::HART_RESET;
		end

		always_ff @(posedge i_clk) begin
			if (!i_rst_n) begin
				state_q <= dbg_hart_pkg::HART_RESET;
				resumeack_q <= 1'b0;
				havereset_q <= 1'b1;
			end else begin
				state_q <= state_d;
				if (hart.set_resume[i])
					resumeack_q <= 1'b0;
				else if (state_q == dbg_hart_pkg::HART_RESUME_REQ
					&& state_d == dbg_hart_pkg::HART_RUNNING)
					resumeack_q <= 1'b1;
				if (i_rst_release[i])
					havereset_q <= 1'b1;
				else if (hart.ack_havereset[i])
					havereset_q <= 1'b0;
			end
		end

		// Requests start in the cycle the set pulse or level arrives
		assign o_hart_req_halt[i] = state_q == dbg_hart_pkg::HART_HALT_REQ
			|| (state_q == dbg_hart_pkg::HART_RUNNING && hart.set_halt[i]);
		assign o_hart_req_resume[i] = state_q == dbg_hart_pkg::HART_RESUME_REQ
			|| (state_q == dbg_hart_pkg::HART_HALTED && hart.set_resume[i]);

		assign hart.halted[i] = state_q == dbg_hart_pkg::HART_HALTED;
		assign hart.running[i] = state_q == dbg_hart_pkg::HART_RUNNING
			|| state_q == dbg_hart_pkg::HART_HALT_REQ;
		assign hart.resumeack[i] = resumeack_q;
		assign hart.havereset[i] = havereset_q;
	end

	a_req_exclusive: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(|(o_hart_req_halt & o_hart_req_resume)));

endmodule

/* hw/dbg_hart_if.sv */
//----------------------------------------
// Link between the DMI register block and
// hart run control, one bit per hart
//----------------------------------------

`include "dbg_macros.svh"

interface dbg_hart_if;

	// Requests from the register block
	logic [`DBG_N_HARTS-1:0] set_halt;
	logic [`DBG_N_HARTS-1:0] set_resume;
	logic [`DBG_N_HARTS-1:0] ack_havereset;

	// Status flags back from run control
	logic [`DBG_N_HARTS-1:0] halted;
	logic [`DBG_N_HARTS-1:0] running;
	logic [`DBG_N_HARTS-1:0] resumeack;
	logic [`DBG_N_HARTS-1:0] havereset;

	modport regs (
		output set_halt, set_resume, ack_havereset,
		input  halted, running, resumeack, havereset
	);

	modport ctrl (
		input  set_halt, set_resume, ack_havereset,
		output halted, running, resumeack, havereset
	);

endinterface

/* hw/dbg_hart_pkg.sv */
//----------------------------------------
// Per-hart run-control state encoding
//----------------------------------------

package dbg_hart_pkg;

	// Run-control view of one hart as seen by the debug module
	typedef enum logic [2:0] {
		HART_RESET,
		HART_RUNNING,
		HART_HALT_REQ,
		HART_HALTED,
		HART_RESUME_REQ
	} hart_state_e;

endpackage

/* hw/dbg_macros.svh */
//----------------------------------------
// Debug module sizing, included by every
// file that needs hart count or widths
//----------------------------------------

`ifndef DBG_MACROS_SVH
`define DBG_MACROS_SVH

// Harts served by the debug module
`define DBG_N_HARTS 2

`define DBG_XLEN 32
`define DBG_DMI_AW 9

// Cycles a reset stays low after its request drops
`define DBG_RST_HOLD 4

`endif

/* hw/dbg_regs_pkg.sv */
//----------------------------------------
// DMI register map and dmcontrol layout
//----------------------------------------

`include "dbg_macros.svh"

package dbg_regs_pkg;

	// Implemented DMI register addresses
	typedef enum logic [`DBG_DMI_AW-1:0] {
		ADDR_DATA0     = 'h04,
		ADDR_DMCONTROL = 'h10,
		ADDR_DMSTATUS  = 'h11,
		ADDR_HALTSUM0  = 'h40
	} dmi_addr_e;

	typedef struct packed {
		logic        haltreq;
		logic        resumereq;
		logic        hartreset;
		logic        ackhavereset;
		logic [10:0] rsvd_27_17;
		logic        hartsel;
		logic [13:0] rsvd_15_2;
		logic        ndmreset;
		logic        dmactive;
	} dmcontrol_t;

	// Debug spec 0.13
	localparam logic [3:0] DMSTATUS_VERSION = 4'd2;

endpackage

/* hw/dbg_reset_timer.sv */
//----------------------------------------
// Stretches hart and system resets, and
// pulses once per hart on release
//----------------------------------------

`include "dbg_macros.svh"

module dbg_reset_timer (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	input  logic [`DBG_N_HARTS-1:0] i_hartreset,
	input  logic                    i_ndmreset,
	output logic [`DBG_N_HARTS-1:0] o_hart_rst_n,
	output logic                    o_sys_rst_n,
	output logic [`DBG_N_HARTS-1:0] o_rst_release
);

	localparam int N = `DBG_N_HARTS;
	localparam int CW = $clog2(`DBG_RST_HOLD + 1);
	localparam int LOW_CYCLES = `DBG_RST_HOLD + 1;

	// Top entry is the system reset, the rest are harts
	logic [N:0]   req;
	logic [N:0]   rst_n;
	logic [N-1:0] release_q;

	assign req = {1'b0, i_hartreset} | {(N + 1){!i_rst_n || i_ndmreset}};

	for (genvar i = 0; i <= N; i++) begin : g_hold
		logic [CW-1:0] cnt_q;

		// Global reset is one of the requests, so it reloads the counter too
		always_ff @(posedge i_clk) begin
			if (req[i])
				cnt_q <= CW'(`DBG_RST_HOLD);
			else if (cnt_q != '0)
				cnt_q <= cnt_q - 1'b1;
		end

		assign rst_n[i] = !req[i] && cnt_q == '0;

		if (i < N) begin : g_release
			always_ff @(posedge i_clk) begin
				if (!i_rst_n)
					release_q[i] <= 1'b0;
				else
					release_q[i] <= !req[i] && cnt_q == CW'(1);
			end
		end

		a_hold_low: assert property (@(posedge i_clk) req[i] |-> !rst_n[i] [*LOW_CYCLES]);
	end

	assign o_hart_rst_n = rst_n[N-1:0];
	assign o_sys_rst_n = rst_n[N];
	assign o_rst_release = release_q;

endmodule

/* hw/dbg_top.sv */
//----------------------------------------
// Debug module for two harts, DMI on one
// side and hart run control on the other
//----------------------------------------

`include "dbg_macros.svh"

module dbg_top (
	input  logic                              i_clk,
	input  logic                              i_rst_n,

	// DMI from the debug transport
	input  logic                              i_dmi_psel,
	input  logic                              i_dmi_penable,
	input  logic                              i_dmi_pwrite,
	input  logic [`DBG_DMI_AW-1:0]            i_dmi_paddr,
	input  logic [`DBG_XLEN-1:0]              i_dmi_pwdata,
	output logic [`DBG_XLEN-1:0]              o_dmi_prdata,
	output logic                              o_dmi_pslverr,

	// Hart run control
	output logic [`DBG_N_HARTS-1:0]           o_hart_req_halt,
	output logic [`DBG_N_HARTS-1:0]           o_hart_req_resume,
	input  logic [`DBG_N_HARTS-1:0]           i_hart_halted,
	input  logic [`DBG_N_HARTS-1:0]           i_hart_running,

	input  logic [`DBG_N_HARTS-1:0]           i_hart_data0_wen,
	input  logic [`DBG_N_HARTS*`DBG_XLEN-1:0] i_hart_data0_wdata,
	output logic [`DBG_XLEN-1:0]              o_data0,

	output logic [`DBG_N_HARTS-1:0]           o_hart_rst_n,
	output logic                              o_sys_rst_n
);

	logic [`DBG_N_HARTS-1:0] hartreset;
	logic                    ndmreset;
	logic [`DBG_N_HARTS-1:0] rst_release;

	dbg_hart_if u_hart_if ();

	dbg_dmi_regs u_regs (
		.i_clk              (i_clk),
		.i_rst_n            (i_rst_n),
		.i_dmi_psel         (i_dmi_psel),
		.i_dmi_penable      (i_dmi_penable),
		.i_dmi_pwrite       (i_dmi_pwrite),
		.i_dmi_paddr        (i_dmi_paddr),
		.i_dmi_pwdata       (i_dmi_pwdata),
		.o_dmi_prdata       (o_dmi_prdata),
		.o_dmi_pslverr      (o_dmi_pslverr),
		.i_hart_data0_wen   (i_hart_data0_wen),
		.i_hart_data0_wdata (i_hart_data0_wdata),
		.o_data0            (o_data0),
		.o_hartreset        (hartreset),
		.o_ndmreset         (ndmreset),
		.hart               (u_hart_if)
	);

	// Run control sees the stretched hart resets, same as the harts do
	dbg_hart_ctrl u_ctrl (
		.i_clk              (i_clk),
		.i_rst_n            (i_rst_n),
		.i_hart_rst_n       (o_hart_rst_n),
		.i_rst_release      (rst_release),
		.i_hart_halted      (i_hart_halted),
		.i_hart_running     (i_hart_running),
		.o_hart_req_halt    (o_hart_req_halt),
		.o_hart_req_resume  (o_hart_req_resume),
		.hart               (u_hart_if)
	);

	dbg_reset_timer u_rst_timer (
		.i_clk              (i_clk),
		.i_rst_n            (i_rst_n),
		.i_hartreset        (hartreset),
		.i_ndmreset         (ndmreset),
		.o_hart_rst_n       (o_hart_rst_n),
		.o_sys_rst_n        (o_sys_rst_n),
		.o_rst_release      (rst_release)
	);

endmodule

/* sim.f */
+incdir+hw
hw/dbg_regs_pkg.sv
hw/dbg_hart_pkg.sv
hw/dbg_hart_if.sv
hw/dbg_dmi_regs.sv
hw/dbg_hart_ctrl.sv
hw/dbg_reset_timer.sv
hw/dbg_top.sv
dv/dbg_tb.sv
